//--- all.f
hw/enc_meas_pkg.sv
hw/enc_regmap_pkg.sv
hw/enc_debounce.sv
hw/enc_quad.sv
hw/enc_period.sv
hw/enc_reg_file.sv
hw/enc_ctrl.sv
test/enc_ctrl_assert.sv
test/enc_ctrl_tb.sv

//--- hw/enc_ctrl.sv
`timescale 1ns/1ps

module enc_ctrl
(
    input  logic sysclk,
    input  logic reset,                                    // sync, active low
    input  logic [1:enc_meas_pkg::num_chan] enc_a,         // raw quadrature lines
    input  logic [1:enc_meas_pkg::num_chan] enc_b,
    input  logic [enc_regmap_pkg::addr_w-1:0] reg_raddr,
    input  logic [enc_regmap_pkg::addr_w-1:0] reg_waddr,
    input  logic [enc_regmap_pkg::data_w-1:0] reg_wdata,
    input  logic reg_wen,
    output logic [enc_regmap_pkg::data_w-1:0] reg_rdata
);

    // ------------------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------------------
    logic [1:enc_meas_pkg::num_chan] enc_a_filt;
    logic [1:enc_meas_pkg::num_chan] enc_b_filt;
    logic [1:enc_meas_pkg::num_chan] dir;          // last step direction per channel
    logic [1:enc_meas_pkg::num_chan] set_enc;      // preload load strobes

    logic [enc_meas_pkg::preload_w-1:0] preload   [1:enc_meas_pkg::num_chan];
    logic [enc_meas_pkg::quad_w-1:0]    quad_data [1:enc_meas_pkg::num_chan];
    logic [enc_meas_pkg::perd_w-1:0]    perd_data [1:enc_meas_pkg::num_chan];

    logic [enc_meas_pkg::tick_w-1:0] tick_cnt;
    logic tick;                                    // period timebase strobe

    // prescaler, one tick every tick_div sysclk cycles
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end
        else
        begin
            tick <= (tick_cnt == enc_meas_pkg::tick_last);
            if (tick_cnt == enc_meas_pkg::tick_last)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // channel slices: filters, position counter, period timer
    // ------------------------------------------------------------------------
    for (genvar ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
    begin : chan_g
        enc_debounce u_filt_a (.sysclk(sysclk), .reset(reset),
                               .raw(enc_a[ch]), .filt(enc_a_filt[ch]));
        enc_debounce u_filt_b (.sysclk(sysclk), .reset(reset),
                               .raw(enc_b[ch]), .filt(enc_b_filt[ch]));

        enc_quad u_quad (.sysclk(sysclk), .reset(reset),
                         .enc_a(enc_a_filt[ch]), .enc_b(enc_b_filt[ch]),
                         .set_enc(set_enc[ch]), .preload(preload[ch]),
                         .quad_data(quad_data[ch]), .dir(dir[ch]));

        enc_period u_perd (.sysclk(sysclk), .reset(reset), .tick(tick),
                           .enc_a(enc_a_filt[ch]), .dir(dir[ch]),
                           .perd_data(perd_data[ch]));
    end

    // bus side
    enc_reg_file u_regs (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .reg_rdata (reg_rdata),
        .preload   (preload),
        .set_enc   (set_enc),
        .quad_data (quad_data),
        .perd_data (perd_data)
    );

endmodule

//--- hw/enc_debounce.sv
`timescale 1ns/1ps

module enc_debounce
(
    input  logic sysclk,
    input  logic reset,   // sync, active low
    input  logic raw,     // async encoder line from the connector
    output logic filt     // cleaned level
);

    logic sync_1;   // first flop, may go metastable
    logic sync_2;   // safe to use
    logic [enc_meas_pkg::dbc_w-1:0] stable_cnt;  // samples that disagreed with filt

    // two stage synchronizer
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end
        else
        begin
            sync_1 <= raw;
            sync_2 <= sync_1;
        end
    end

    // ------------------------------------------------------------------------
    // stability counter, output follows after debounce_len differing samples
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            stable_cnt <= '0;
            filt       <= 1'b0;
        end
        else if (sync_2 == filt)
            stable_cnt <= '0;                          // glitch gone, start over
        else if (stable_cnt == enc_meas_pkg::dbc_last)
        begin
            filt       <= sync_2;                      // held long enough
            stable_cnt <= '0;
        end
        else
            stable_cnt <= stable_cnt + 1'b1;
    end

endmodule

//--- hw/enc_meas_pkg.sv
package enc_meas_pkg;

    // ------------------------------------------------------------------------
    // channel layout and data widths
    // ------------------------------------------------------------------------
    localparam int num_chan   = 4;              // channels 1..4, same as bus chan field
    localparam int preload_w  = 24;             // preload / raw position width
    localparam int quad_w     = preload_w + 1;  // msb is the overflow or borrow flag
    localparam int perd_w     = 32;             // period word as seen on the bus
    localparam int perd_cnt_w = perd_w - 1;     // tick count, bit 31 is direction

    // half scale, so the counter can swing either way after power up
    localparam logic [preload_w-1:0] preload_default = 24'h800000;

    // ------------------------------------------------------------------------
    // input filter
    // ------------------------------------------------------------------------
    localparam int debounce_len = 4;                           // stable samples needed
    localparam int dbc_w        = $clog2(debounce_len);
    localparam logic [dbc_w-1:0] dbc_last = dbc_w'(debounce_len - 1);

    // ------------------------------------------------------------------------
    // period tick prescaler
    // ------------------------------------------------------------------------
    localparam int tick_div = 16;               // sysclk cycles per period tick
    localparam int tick_w   = $clog2(tick_div);
    localparam logic [tick_w-1:0] tick_last = tick_w'(tick_div - 1);

endpackage

//--- hw/enc_period.sv
`timescale 1ns/1ps

module enc_period
(
    input  logic sysclk,
    input  logic reset,
    input  logic tick,                                     // one cycle per tick_div
    input  logic enc_a,                                    // filtered a line
    input  logic dir,                                      // from the position counter
    output logic [enc_meas_pkg::perd_w-1:0] perd_data      // {dir, ticks}
);

    logic a_prev;
    logic a_edge;
    logic cnt_full;
    logic [enc_meas_pkg::perd_cnt_w-1:0] tick_cnt;         // ticks since last a edge

    assign a_edge   = enc_a ^ a_prev;   // rising or falling
    assign cnt_full = &tick_cnt;        // stop here for very slow motion

    // ------------------------------------------------------------------------
    // tick counter, restarts on every a edge
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            a_prev    <= 1'b0;
            tick_cnt  <= '0;
            perd_data <= '0;
        end
        else
        begin
            a_prev <= enc_a;
            if (a_edge)
            begin
                perd_data <= {dir, tick_cnt};   // hold last full interval
                tick_cnt  <= '0;
            end
            else if (tick && !cnt_full)
                tick_cnt <= tick_cnt + 1'b1;    // saturating
        end
    end

endmodule

//--- hw/enc_quad.sv
`timescale 1ns/1ps

module enc_quad
(
    input  logic sysclk,
    input  logic reset,
    input  logic enc_a,                                    // filtered a line
    input  logic enc_b,                                    // filtered b line
    input  logic set_enc,                                  // one cycle load strobe
    input  logic [enc_meas_pkg::preload_w-1:0] preload,
    output logic [enc_meas_pkg::quad_w-1:0] quad_data,     // {ovf, count}
    output logic dir                                       // 1 = counting up
);

    logic a_prev;
    logic b_prev;
    logic edge_seen;      // either line toggled
    logic step_up;        // quadrature phase says up
    logic ovf;            // sticky wrap / borrow flag
    logic [enc_meas_pkg::preload_w-1:0] count;
    logic [enc_meas_pkg::quad_w-1:0] step;                 // count +/- 1, msb is carry

    // ------------------------------------------------------------------------
    // x4 decode
    // ------------------------------------------------------------------------
    always_comb
    begin
        edge_seen = (enc_a ^ a_prev) | (enc_b ^ b_prev);
        // a leading b: 00 -> 10 -> 11 -> 01, each gives a ^ b_prev = 1
        step_up   = enc_a ^ b_prev;
        if (step_up)
            step = {1'b0, count} + 1'b1;
        else
            step = {1'b0, count} - 1'b1;   // borrow shows up in the msb
    end

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
            count  <= enc_meas_pkg::preload_default;
            ovf    <= 1'b0;
            dir    <= 1'b0;
        end
        else
        begin
            a_prev <= enc_a;
            b_prev <= enc_b;
            if (set_enc)
            begin
                count <= preload;          // load wins over a coincident edge
                ovf   <= 1'b0;
            end
            else if (edge_seen)
            begin
                count <= step[enc_meas_pkg::preload_w-1:0];
                ovf   <= ovf | step[enc_meas_pkg::quad_w-1];
                dir   <= step_up;
            end
        end
    end

    assign quad_data = {ovf, count};

endmodule

//--- hw/enc_reg_file.sv
`timescale 1ns/1ps

module enc_reg_file
(
    input  logic sysclk,
    input  logic reset,
    input  logic [enc_regmap_pkg::addr_w-1:0] reg_raddr,
    input  logic [enc_regmap_pkg::addr_w-1:0] reg_waddr,
    input  logic [enc_regmap_pkg::data_w-1:0] reg_wdata,
    input  logic reg_wen,                                  // single cycle write strobe
    output logic [enc_regmap_pkg::data_w-1:0] reg_rdata,
    output logic [enc_meas_pkg::preload_w-1:0] preload [1:enc_meas_pkg::num_chan],
    output logic [1:enc_meas_pkg::num_chan] set_enc,       // load pulses to counters
    input  logic [enc_meas_pkg::quad_w-1:0] quad_data [1:enc_meas_pkg::num_chan],
    input  logic [enc_meas_pkg::perd_w-1:0] perd_data [1:enc_meas_pkg::num_chan]
);

    logic [3:0] wr_blk;
    logic [3:0] wr_chan;
    logic [3:0] wr_off;
    logic [3:0] rd_chan;
    logic [3:0] rd_off;
    logic wr_load;     // preload write to main block, channel not yet checked

    assign wr_blk  = reg_waddr[enc_regmap_pkg::blk_hi:enc_regmap_pkg::blk_lo];
    assign wr_chan = reg_waddr[enc_regmap_pkg::chan_hi:enc_regmap_pkg::chan_lo];
    assign wr_off  = reg_waddr[enc_regmap_pkg::off_hi:enc_regmap_pkg::off_lo];
    assign rd_chan = reg_raddr[enc_regmap_pkg::chan_hi:enc_regmap_pkg::chan_lo];
    assign rd_off  = reg_raddr[enc_regmap_pkg::off_hi:enc_regmap_pkg::off_lo];

    assign wr_load = reg_wen && (wr_blk == enc_regmap_pkg::addr_main)
                             && (wr_off == enc_regmap_pkg::off_enc_load);

    // ------------------------------------------------------------------------
    // preload registers and one cycle load pulses
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            set_enc <= '0;
            for (int i = 1; i <= enc_meas_pkg::num_chan; i++)
                preload[i] <= enc_meas_pkg::preload_default;
        end
        else
        begin
            for (int i = 1; i <= enc_meas_pkg::num_chan; i++)
            begin
                set_enc[i] <= wr_load && (wr_chan == 4'(i));   // drops again next cycle
                if (wr_load && (wr_chan == 4'(i)))
                    preload[i] <= reg_wdata[enc_meas_pkg::preload_w-1:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // read mux, block code ignored on reads
    // ------------------------------------------------------------------------
    always_comb
    begin
        reg_rdata = '0;   // channel 0, >4 and unknown offsets read zero
        for (int i = 1; i <= enc_meas_pkg::num_chan; i++)
        begin
            if (rd_chan == 4'(i))
            begin
                if (rd_off == enc_regmap_pkg::off_enc_load)
                    reg_rdata[enc_meas_pkg::preload_w-1:0] = preload[i];
                else if (rd_off == enc_regmap_pkg::off_enc_data)
                    reg_rdata[enc_meas_pkg::quad_w-1:0] = quad_data[i];    // ovf in bit 24
                else if (rd_off == enc_regmap_pkg::off_per_data)
                    reg_rdata[enc_meas_pkg::perd_w-1:0] = perd_data[i];
            end
        end
    end

endmodule

//--- hw/enc_regmap_pkg.sv
package enc_regmap_pkg;

    // bus widths
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // ------------------------------------------------------------------------
    // address fields: [15:12] block, [7:4] channel, [3:0] offset
    // ------------------------------------------------------------------------
    localparam int blk_hi  = 15;
    localparam int blk_lo  = 12;
    localparam int chan_hi = 7;
    localparam int chan_lo = 4;
    localparam int off_hi  = 3;
    localparam int off_lo  = 0;

    localparam logic [3:0] addr_main = 4'h0;  // main block, only checked on writes

    // per channel register offsets
    localparam logic [3:0] off_enc_load = 4'd4;  // preload, r/w
    localparam logic [3:0] off_enc_data = 4'd5;  // position incl. overflow, ro
    localparam logic [3:0] off_per_data = 4'd6;  // period with dir in msb, ro

endpackage

//--- run.sh
#!/bin/sh
# build with verilator, run the testbench, judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module enc_ctrl_tb -f all.f \
    -o enc_ctrl_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/enc_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"

//--- test/enc_ctrl_assert.sv
`timescale 1ns/1ps

module enc_ctrl_assert
(
    input logic sysclk,
    input logic reset,
    input logic [enc_regmap_pkg::addr_w-1:0] reg_raddr,
    input logic [enc_regmap_pkg::data_w-1:0] reg_rdata,
    input logic [1:enc_meas_pkg::num_chan] set_enc
);

    logic [3:0] rd_off;
    logic off_mapped;   // preload, position or period

    assign rd_off     = reg_raddr[enc_regmap_pkg::off_hi:enc_regmap_pkg::off_lo];
    assign off_mapped = (rd_off == enc_regmap_pkg::off_enc_load)
                     || (rd_off == enc_regmap_pkg::off_enc_data)
                     || (rd_off == enc_regmap_pkg::off_per_data);

    pulse_once: assert property (@(posedge sysclk) disable iff (!reset)
                                 (set_enc & $past(set_enc)) == '0)
        else $error("set_enc high for two cycles in a row");

    reset_quiet: assert property (@(posedge sysclk) !reset |=> set_enc == '0)
        else $error("set_enc not cleared by reset");

    unmapped_zero: assert property (@(posedge sysclk) !off_mapped |-> reg_rdata == '0)
        else $error("nonzero read data from an unmapped offset");

endmodule

bind enc_reg_file enc_ctrl_assert u_reg_chk (.sysclk(sysclk), .reset(reset),
    .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .set_enc(set_enc));

//--- test/enc_ctrl_tb.sv
`timescale 1ns/1ps

module enc_ctrl_tb;

    // ---------------------------------------------------------------------------
    // run length, timeout is twice the summed test lengths
    // ---------------------------------------------------------------------------
    localparam int q_fast   = 12;   // quarter step gap, well above the filter delay
    localparam int q_slow   = 80;   // quarter step gap for period runs
    localparam int n_cyc    = 3;    // full quadrature cycles per run
    localparam int settle   = 16;
    localparam int run_fast = 4 * n_cyc * q_fast + settle;
    localparam int run_slow = 4 * n_cyc * q_slow + settle;
    localparam int timeout_cycles = 2 * (800 + 10 * run_fast + 8 * run_slow);

    logic sysclk;
    logic reset;
    logic [1:enc_meas_pkg::num_chan] enc_a;   // raw lines into the DUT
    logic [1:enc_meas_pkg::num_chan] enc_b;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic reg_wen;
    logic [31:0] reg_rdata;
    int err_cnt;
    int cycle_cnt;

    enc_ctrl DUT (.sysclk(sysclk), .reset(reset), .enc_a(enc_a), .enc_b(enc_b),
                  .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
                  .reg_wen(reg_wen), .reg_rdata(reg_rdata));

    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;    // 100 ns period

    // {block, 0, chan, offset}
    function automatic logic [15:0] reg_addr(input logic [3:0] blk, input int ch,
                                             input logic [3:0] off);
        return {blk, 4'h0, 4'(ch), off};
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp, input int tol);
        logic [31:0] diff;
        diff = (got > exp) ? got - exp : exp - got;
        if ($isunknown(got) || diff > 32'(tol))
        begin
            $display("mismatch at %0t ns: %s got 0x%h expected 0x%h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic bus_write(input int ch, input logic [3:0] blk, input logic [3:0] off,
                             input logic [31:0] data);
        @(posedge sysclk);
        reg_waddr <= reg_addr(blk, ch, off);
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;   // one cycle strobe
    endtask

    // read mux is combinational, sampled mid cycle
    task automatic read_check(input int ch, input logic [3:0] off, input logic [31:0] exp,
                              input int tol, input string what);
        @(posedge sysclk);
        reg_raddr <= reg_addr(enc_regmap_pkg::addr_main, ch, off);
        @(negedge sysclk);
        check_val($sformatf("ch%0d %s", ch, what), reg_rdata, exp, tol);
    endtask

    // forward is a leading b, 00 10 11 01, reverse swaps the two lines
    task automatic run_motion(input int ch, input bit fwd, input int cycles, input int gap);
        bit a;
        bit b;
        for (int n = 0; n < cycles * 4; n++)
        begin
            a = (n % 4) < 2;
            b = (n % 4) == 1 || (n % 4) == 2;
            @(posedge sysclk);
            enc_a[ch] <= fwd ? a : b;
            enc_b[ch] <= fwd ? b : a;
            repeat (gap - 1) @(posedge sysclk);
        end
        repeat (settle) @(posedge sysclk);   // filter plus counter latency
    endtask

    // ---------------------------------------------------------------------------
    // directed tests
    // ---------------------------------------------------------------------------
    task automatic test_reset_values();
        for (int ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
        begin
            read_check(ch, enc_regmap_pkg::off_enc_load, 32'h0080_0000, 0, "reset preload");
            read_check(ch, enc_regmap_pkg::off_enc_data, 32'h0080_0000, 0, "reset position");
            read_check(ch, enc_regmap_pkg::off_per_data, 32'h0, 0, "reset period");
        end
    endtask

    task automatic test_preload();
        logic [31:0] data;
        for (int ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
        begin
            data = $urandom;   // top byte is dropped by the register
            bus_write(ch, enc_regmap_pkg::addr_main, enc_regmap_pkg::off_enc_load, data);
            read_check(ch, enc_regmap_pkg::off_enc_load, data & 32'hFF_FFFF, 0, "preload");
            read_check(ch, enc_regmap_pkg::off_enc_data, data & 32'hFF_FFFF, 0, "position");
            bus_write(ch, 4'h3, enc_regmap_pkg::off_enc_load, ~data);   // wrong block
            bus_write(ch, enc_regmap_pkg::addr_main, 4'h7, ~data);      // wrong offset
            read_check(ch, enc_regmap_pkg::off_enc_load, data & 32'hFF_FFFF, 0, "kept preload");
            read_check(ch, enc_regmap_pkg::off_enc_data, data & 32'hFF_FFFF, 0, "kept position");
        end
    endtask

    task automatic test_motion(input bit fwd);
        logic [23:0] base;
        logic [31:0] exp;
        for (int ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
        begin
            base = 24'($urandom & 32'h007F_FF00) | 24'h00_0100;   // far from either wrap
            bus_write(ch, enc_regmap_pkg::addr_main, enc_regmap_pkg::off_enc_load, 32'(base));
            run_motion(ch, fwd, n_cyc, q_fast);
            exp = fwd ? base + 4 * n_cyc : base - 4 * n_cyc;
            read_check(ch, enc_regmap_pkg::off_enc_data, exp, 0, fwd ? "forward" : "reverse");
        end
    endtask

    task automatic test_wrap();
        for (int ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
        begin
            bus_write(ch, enc_regmap_pkg::addr_main, enc_regmap_pkg::off_enc_load, 32'd2);
            run_motion(ch, 1'b0, 1, q_fast);
            // 2 - 4 borrows to 0xfffffe, overflow in bit 24
            read_check(ch, enc_regmap_pkg::off_enc_data, 32'h01FF_FFFE, 0, "wrapped position");
            bus_write(ch, enc_regmap_pkg::addr_main, enc_regmap_pkg::off_enc_load, 32'h12_3456);
            read_check(ch, enc_regmap_pkg::off_enc_data, 32'h12_3456, 0, "overflow cleared");
        end
    endtask

    task automatic test_period();
        logic [31:0] ticks;
        ticks = 32'(2 * q_slow / enc_meas_pkg::tick_div);   // a edges every second step
        for (int ch = 1; ch <= enc_meas_pkg::num_chan; ch++)
        begin
            run_motion(ch, 1'b1, n_cyc, q_slow);
            read_check(ch, enc_regmap_pkg::off_per_data, 32'h8000_0000 | ticks, 1, "fwd period");
            run_motion(ch, 1'b0, n_cyc, q_slow);
            read_check(ch, enc_regmap_pkg::off_per_data, ticks, 1, "rev period");
        end
    endtask

    task automatic test_unmapped();
        for (int ch = 0; ch < 16; ch++)
            for (int off = 0; off < 16; off++)
                if (ch < 1 || ch > 4 || off < 4 || off > 6)
                    read_check(ch, 4'(off), 32'h0, 0, "unmapped read");
    endtask

    initial
    begin
        err_cnt   = 0;
        enc_a     = '0;
        enc_b     = '0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        reset     = 1'b0;
        void'($urandom(44060));
        repeat (3) @(posedge sysclk);
        reset <= 1'b1;
        test_reset_values();
        test_preload();
        test_motion(1'b1);
        test_motion(1'b0);
        test_wrap();
        test_period();
        test_unmapped();
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge sysclk);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
